// File: source/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath sizes.
`define DATA_W     32
`define REG_ADDR_W 5
`define REG_COUNT  32

// named registers, MIPS numbering.
`define REG_ZERO 5'd0 // hard-wired zero.
`define REG_AT   5'd1
`define REG_V0   5'd2
`define REG_A0   5'd4
`define REG_T0   5'd8
`define REG_S0   5'd16
`define REG_GP   5'd28
`define REG_SP   5'd29
`define REG_FP   5'd30
`define REG_RA   5'd31

`endif

// File: source/mips_pkg.sv
package mips_pkg;

	// primary opcode, instr[31:26].
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_SLTI  = 6'h0a,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d
	} opcode_t;

	// R-type function field, instr[5:0].
	typedef enum logic [5:0] {
		F_ADD = 6'h20,
		F_SUB = 6'h22,
		F_AND = 6'h24,
		F_OR  = 6'h25,
		F_XOR = 6'h26,
		F_NOR = 6'h27,
		F_SLT = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_NOR = 3'd5,
		ALU_SLT = 3'd6
	} alu_op_t;

	// one instruction at a time, three edges from accept to writeback.
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_READ = 2'd1,
		S_EXEC = 2'd2,
		S_WB   = 2'd3
	} state_t;

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   write_ena,
	input  logic [`REG_ADDR_W-1:0] address1,
	input  logic [`REG_ADDR_W-1:0] address2,
	input  logic [`REG_ADDR_W-1:0] address3,
	input  logic [`DATA_W-1:0]     write_data,
	output logic [`DATA_W-1:0]     read_data1,
	output logic [`DATA_W-1:0]     read_data2
);

	// register 0 has no storage, it always reads zero.
	logic [`DATA_W-1:0] regs [1:`REG_COUNT-1];

	function automatic logic [`DATA_W-1:0] read_reg(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == `REG_ZERO) begin
			return '0;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			read_data1 <= '0;
			read_data2 <= '0;
		end else begin
			if (write_ena && address3 != `REG_ZERO) begin
				regs[address3] <= write_data; // writes to zero are dropped.
			end
			// reads see the value before this edge's write.
			read_data1 <= read_reg(address1);
			read_data2 <= read_reg(address2);
		end
	end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module alu (
	input  mips_pkg::alu_op_t  op,
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	output logic [`DATA_W-1:0] result
);

	logic less; // signed compare for slt.

	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: begin
				result = a + b; // wraps, no overflow trap.
			end
			mips_pkg::ALU_SUB: begin
				result = a - b;
			end
			mips_pkg::ALU_AND: begin
				result = a & b;
			end
			mips_pkg::ALU_OR: begin
				result = a | b;
			end
			mips_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			mips_pkg::ALU_NOR: begin
				result = ~(a | b);
			end
			mips_pkg::ALU_SLT: begin
				result = {{(`DATA_W-1){1'b0}}, less};
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: source/core_ctrl.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module core_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	output logic                   ready,
	output logic [`REG_ADDR_W-1:0] rs_addr,
	output logic [`REG_ADDR_W-1:0] rt_addr,
	input  logic [`DATA_W-1:0]     rd_data1,
	input  logic [`DATA_W-1:0]     rd_data2,
	output mips_pkg::alu_op_t      alu_op,
	output logic [`DATA_W-1:0]     alu_a,
	output logic [`DATA_W-1:0]     alu_b,
	input  logic [`DATA_W-1:0]     alu_result,
	output logic                   write_ena,
	output logic [`REG_ADDR_W-1:0] write_addr,
	output logic [`DATA_W-1:0]     write_data,
	output logic                   wb_valid,
	output logic                   illegal,
	output logic [`REG_ADDR_W-1:0] wb_addr,
	output logic [`DATA_W-1:0]     wb_data
);

	mips_pkg::state_t state;

	// decode of the incoming word.
	mips_pkg::alu_op_t      dec_op;
	logic [`REG_ADDR_W-1:0] dec_dest;
	logic                   dec_imm_sel;
	logic                   dec_sext;
	logic                   dec_illegal;
	logic [`DATA_W-1:0]     dec_imm;

	// held for the rest of the instruction.
	mips_pkg::alu_op_t      op_q;
	logic [`REG_ADDR_W-1:0] rs_q;
	logic [`REG_ADDR_W-1:0] rt_q;
	logic [`REG_ADDR_W-1:0] dest_q;
	logic                   imm_sel_q;
	logic                   illegal_q;
	logic [`DATA_W-1:0]     imm_q;
	logic [`DATA_W-1:0]     result_q;

	always_comb begin
		dec_op      = mips_pkg::ALU_ADD;
		dec_dest    = instr[20:16]; // rt for I-type.
		dec_imm_sel = 1'b1;
		dec_sext    = 1'b1;
		dec_illegal = 1'b0;
		case (mips_pkg::opcode_t'(instr[31:26]))
			mips_pkg::OP_RTYPE: begin
				dec_dest    = instr[15:11];
				dec_imm_sel = 1'b0;
				case (mips_pkg::funct_t'(instr[5:0]))
					mips_pkg::F_ADD: dec_op = mips_pkg::ALU_ADD;
					mips_pkg::F_SUB: dec_op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND: dec_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:  dec_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR: dec_op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR: dec_op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT: dec_op = mips_pkg::ALU_SLT;
					default:         dec_illegal = 1'b1;
				endcase
			end
			mips_pkg::OP_ADDI: dec_op = mips_pkg::ALU_ADD;
			mips_pkg::OP_SLTI: dec_op = mips_pkg::ALU_SLT;
			mips_pkg::OP_ANDI: begin
				dec_op   = mips_pkg::ALU_AND;
				dec_sext = 1'b0; // logical ops zero extend.
			end
			mips_pkg::OP_ORI: begin
				dec_op   = mips_pkg::ALU_OR;
				dec_sext = 1'b0;
			end
			default: dec_illegal = 1'b1;
		endcase
	end

	assign dec_imm = dec_sext ? {{(`DATA_W-16){instr[15]}}, instr[15:0]}
	                          : {{(`DATA_W-16){1'b0}}, instr[15:0]};

	always_ff @(posedge clk) begin
		if (!rst) begin
			state     <= mips_pkg::S_IDLE;
			rs_q      <= `REG_ZERO;
			rt_q      <= `REG_ZERO;
			illegal_q <= 1'b0;
		end else begin
			case (state)
				mips_pkg::S_IDLE: begin
					if (instr_valid) begin
						state     <= mips_pkg::S_READ;
						rs_q      <= instr[25:21];
						rt_q      <= instr[20:16];
						illegal_q <= dec_illegal;
					end
				end
				mips_pkg::S_READ: state <= mips_pkg::S_EXEC;
				mips_pkg::S_EXEC: state <= mips_pkg::S_WB;
				default:          state <= mips_pkg::S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ready && instr_valid) begin
			op_q      <= dec_op;
			dest_q    <= dec_dest;
			imm_sel_q <= dec_imm_sel;
			imm_q     <= dec_imm;
		end
		if (state == mips_pkg::S_EXEC) begin
			result_q <= alu_result;
		end
	end

	assign ready   = (state == mips_pkg::S_IDLE);
	assign rs_addr = rs_q;
	assign rt_addr = rt_q;

	// operands come straight from the register file outputs in S_EXEC.
	assign alu_op = op_q;
	assign alu_a  = rd_data1;
	assign alu_b  = imm_sel_q ? imm_q : rd_data2;

	assign wb_valid   = (state == mips_pkg::S_WB) && !illegal_q;
	assign illegal    = (state == mips_pkg::S_WB) && illegal_q;
	assign write_ena  = wb_valid;
	assign write_addr = dest_q;
	assign write_data = result_q;
	assign wb_addr    = dest_q;
	assign wb_data    = result_q;

endmodule

// File: source/mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	output logic                   ready,
	output logic                   wb_valid,
	output logic [`REG_ADDR_W-1:0] wb_addr,
	output logic [`DATA_W-1:0]     wb_data,
	output logic                   illegal
);

	logic [`REG_ADDR_W-1:0] rs_addr;
	logic [`REG_ADDR_W-1:0] rt_addr;
	logic [`DATA_W-1:0]     rd_data1;
	logic [`DATA_W-1:0]     rd_data2;
	logic                   write_ena;
	logic [`REG_ADDR_W-1:0] write_addr;
	logic [`DATA_W-1:0]     write_data;
	mips_pkg::alu_op_t      alu_op;
	logic [`DATA_W-1:0]     alu_a;
	logic [`DATA_W-1:0]     alu_b;
	logic [`DATA_W-1:0]     alu_result;

	core_ctrl i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ready       (ready),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.rd_data1    (rd_data1),
		.rd_data2    (rd_data2),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_result  (alu_result),
		.write_ena   (write_ena),
		.write_addr  (write_addr),
		.write_data  (write_data),
		.wb_valid    (wb_valid),
		.illegal     (illegal),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	reg_file i_regs (
		.clk        (clk),
		.rst        (rst),
		.write_ena  (write_ena),
		.address1   (rs_addr),
		.address2   (rt_addr),
		.address3   (write_addr),
		.write_data (write_data),
		.read_data1 (rd_data1),
		.read_data2 (rd_data2)
	);

	alu i_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result)
	);

endmodule

// File: tb/mips_core_props.sv
`timescale 1ns/1ps

module mips_core_props (
	input logic             clk,
	input logic             rst,
	input logic             instr_valid,
	input logic             ready,
	input logic             wb_valid,
	input logic             illegal,
	input mips_pkg::state_t state
);

	// busy through read, execute and writeback, then free again.
	accept_busy: assert property (@(posedge clk) disable iff (!rst)
		ready && instr_valid |=> (!ready && state == mips_pkg::S_READ)
			##1 (!ready && state == mips_pkg::S_EXEC)
			##1 (!ready && state == mips_pkg::S_WB) ##1 ready)
		else $error("ready or the FSM state is wrong after an accept");

	wb_single_pulse: assert property (@(posedge clk) disable iff (!rst)
		wb_valid || illegal |=> !(wb_valid || illegal))
		else $error("writeback or illegal pulse lasts more than one cycle");

	// fixed latency from accept to the writeback pulse.
	accept_to_wb: assert property (@(posedge clk) disable iff (!rst)
		ready && instr_valid |-> ##3 (wb_valid || illegal))
		else $error("no writeback or illegal pulse three edges after accept");

endmodule

bind mips_core mips_core_props i_props (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.ready       (ready),
	.wb_valid    (wb_valid),
	.illegal     (illegal),
	.state       (i_ctrl.state)
);

// File: tb/tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mips_core;

	localparam int READY_TIMEOUT = 20;

	logic                   clk;
	logic                   rst;
	logic                   instr_valid;
	logic [`DATA_W-1:0]     instr;
	logic                   ready;
	logic                   wb_valid;
	logic [`REG_ADDR_W-1:0] wb_addr;
	logic [`DATA_W-1:0]     wb_data;
	logic                   illegal;

	logic [`DATA_W-1:0]            model [`REG_COUNT]; // reference register contents.
	logic [`DATA_W+`REG_ADDR_W:0]  exp_q [$];          // {illegal, dest, value} per accept.
	logic [`DATA_W+`REG_ADDR_W:0]  exp_rec;
	logic [31:0]                   rng_state;
	int check_count  = 0;
	int check_errors = 0;
	int stim_errors  = 0;
	int accept_count = 0;
	int pulse_count  = 0;

	mips_core i_dut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ready       (ready),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.illegal     (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'h00, funct};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] legal_word(input logic [31:0] f, input logic [3:0] kind);
		case (kind)
			4'd0: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_ADD);
			4'd1: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_SUB);
			4'd2: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_AND);
			4'd3: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_OR);
			4'd4: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_XOR);
			4'd5: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_NOR);
			4'd6: return rtype(f[25:21], f[20:16], f[15:11], mips_pkg::F_SLT);
			4'd7: return itype(mips_pkg::OP_ADDI, f[25:21], f[20:16], f[15:0]);
			4'd8: return itype(mips_pkg::OP_SLTI, f[25:21], f[20:16], f[15:0]);
			4'd9: return itype(mips_pkg::OP_ANDI, f[25:21], f[20:16], f[15:0]);
			default: return itype(mips_pkg::OP_ORI, f[25:21], f[20:16], f[15:0]);
		endcase
	endfunction

	// moves a legal code onto an unused one.
	function automatic logic [31:0] illegal_word(input logic [31:0] r);
		logic [5:0] op;
		logic [5:0] fn;
		op = r[31:26];
		fn = r[5:0];
		if (r[6]) begin
			if (fn inside {mips_pkg::F_ADD, mips_pkg::F_SUB, mips_pkg::F_AND, mips_pkg::F_OR,
				mips_pkg::F_XOR, mips_pkg::F_NOR, mips_pkg::F_SLT}) begin
				fn = fn ^ 6'h10;
			end
			return {6'h00, r[25:6], fn};
		end
		if (op inside {mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI, mips_pkg::OP_SLTI,
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI}) begin
			op = op | 6'h30;
		end
		return {op, r[25:0]};
	endfunction

	function automatic void ref_exec(input logic [`DATA_W-1:0] regs [`REG_COUNT],
		input logic [31:0] ins, output logic ill, output logic [`REG_ADDR_W-1:0] dest,
		output logic [`DATA_W-1:0] value);
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] imm_s;
		logic [`DATA_W-1:0] imm_z;
		a     = regs[ins[25:21]];
		b     = regs[ins[20:16]];
		imm_s = {{(`DATA_W-16){ins[15]}}, ins[15:0]};
		imm_z = {{(`DATA_W-16){1'b0}}, ins[15:0]};
		ill   = 1'b0;
		dest  = ins[20:16];
		value = '0;
		case (ins[31:26])
			mips_pkg::OP_RTYPE: begin
				dest = ins[15:11];
				case (ins[5:0])
					mips_pkg::F_ADD: value = a + b;
					mips_pkg::F_SUB: value = a - b;
					mips_pkg::F_AND: value = a & b;
					mips_pkg::F_OR:  value = a | b;
					mips_pkg::F_XOR: value = a ^ b;
					mips_pkg::F_NOR: value = ~(a | b);
					mips_pkg::F_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:         ill = 1'b1;
				endcase
			end
			mips_pkg::OP_ADDI: value = a + imm_s;
			mips_pkg::OP_SLTI: value = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
			mips_pkg::OP_ANDI: value = a & imm_z;
			mips_pkg::OP_ORI:  value = a | imm_z;
			default:           ill = 1'b1;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			check_errors++;
			$display("Mismatch %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, check errors %0d, other errors %0d",
			check_count, check_errors, stim_errors);
		if (check_errors + stim_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	task automatic wait_ready(input string what);
		int cycles;
		cycles = 0;
		while (!ready && cycles < READY_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!ready) begin
			stim_errors++;
			$display("Error: the core never became ready %s", what);
			finish_run();
		end
	endtask

	task automatic issue(input logic [31:0] ins, input bit noise);
		logic                   ill;
		logic [`REG_ADDR_W-1:0] dest;
		logic [`DATA_W-1:0]     value;
		wait_ready("for a new instruction");
		ref_exec(model, ins, ill, dest, value);
		exp_q.push_back({ill, dest, value});
		instr       = ins;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		accept_count++;
		if (noise) begin
			rng_state = xorshift32(rng_state);
			instr     = rng_state; // strobes while busy are dropped.
			repeat (2) begin
				@(posedge clk);
				#1;
			end
		end
		instr_valid = 1'b0;
	endtask

	// writeback is stable mid cycle.
	always @(negedge clk) begin
		if (!rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				model[i] = '0;
			end
		end else if (wb_valid || illegal) begin
			pulse_count++;
			if (exp_q.size() == 0) begin
				check_errors++;
				$display("Error: writeback pulse without an accepted instruction");
			end else begin
				exp_rec = exp_q.pop_front();
				check("illegal", 32'(illegal), 32'(exp_rec[`DATA_W+`REG_ADDR_W]));
				check("wb_valid", 32'(wb_valid), 32'(!exp_rec[`DATA_W+`REG_ADDR_W]));
				if (!exp_rec[`DATA_W+`REG_ADDR_W]) begin
					check("wb_addr", 32'(wb_addr), 32'(exp_rec[`DATA_W+`REG_ADDR_W-1:`DATA_W]));
					check("wb_data", wb_data, exp_rec[`DATA_W-1:0]);
					if (exp_rec[`DATA_W+`REG_ADDR_W-1:`DATA_W] != `REG_ZERO) begin
						model[exp_rec[`DATA_W+`REG_ADDR_W-1:`DATA_W]] = exp_rec[`DATA_W-1:0];
					end
				end
			end
		end
	end

	initial begin
		logic [31:0]            word;
		logic [`REG_ADDR_W-1:0] target;
		rst         = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		rng_state   = 32'h5df;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b1;

		for (int r = 0; r < `REG_COUNT; r++) begin
			issue(rtype(5'(r), `REG_ZERO, 5'(r), mips_pkg::F_ADD), 1'b0);
		end

		issue(itype(mips_pkg::OP_ADDI, `REG_ZERO, `REG_SP, 16'hfff0), 1'b0);
		issue(itype(mips_pkg::OP_ADDI, `REG_ZERO, `REG_RA, 16'h8000), 1'b0);
		issue(itype(mips_pkg::OP_ORI, `REG_ZERO, `REG_T0, 16'h8001), 1'b0);
		issue(itype(mips_pkg::OP_ORI, `REG_SP, `REG_A0, 16'h00ff), 1'b0);
		issue(itype(mips_pkg::OP_ANDI, `REG_SP, `REG_V0, 16'hff0f), 1'b0);
		issue(itype(mips_pkg::OP_SLTI, `REG_SP, `REG_AT, 16'h0001), 1'b0);

		// register 0 reports the write but keeps reading zero.
		issue(itype(mips_pkg::OP_ADDI, `REG_ZERO, `REG_ZERO, 16'h1234), 1'b0);
		issue(rtype(`REG_ZERO, `REG_SP, `REG_ZERO, mips_pkg::F_SUB), 1'b0);
		issue(rtype(`REG_ZERO, `REG_ZERO, `REG_S0, mips_pkg::F_OR), 1'b0);

		for (int n = 0; n < 300; n++) begin
			rng_state = xorshift32(rng_state);
			word      = rng_state;
			rng_state = xorshift32(rng_state);
			issue(legal_word(word, 4'(rng_state % 32'd11)), n % 5 == 0);
		end

		for (int n = 0; n < 40; n++) begin
			rng_state = xorshift32(rng_state);
			word      = illegal_word(rng_state);
			issue(word, n % 3 == 0);
			target = (word[31:26] == mips_pkg::OP_RTYPE) ? word[15:11] : word[20:16];
			issue(rtype(target, `REG_ZERO, target, mips_pkg::F_OR), 1'b0); // target unchanged.
		end

		wait_ready("after the last instruction");
		if (pulse_count != accept_count || exp_q.size() != 0) begin
			stim_errors++;
			$display("Error: %0d writeback or illegal pulses for %0d accepted instructions",
				pulse_count, accept_count);
		end
		finish_run();
	end

endmodule

// File: all.f
+incdir+source
source/mips_pkg.sv
source/reg_file.sv
source/alu.sv
source/core_ctrl.sv
source/mips_core.sv
tb/mips_core_props.sv
tb/tb_mips_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED
SOURCES   := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
